//--- design/dbus_macros.svh
`ifndef DBUS_MACROS_SVH
`define DBUS_MACROS_SVH

// region matches, compared against the top bits of the master address
`define DBUS_RAM_BASE   8'h00       // address bits 31..24
`define DBUS_FLASH_BASE 8'h1e       // address bits 31..24
`define DBUS_UART_BASE  28'h1fd003f // address bits 31..4
`define DBUS_GPIO_BASE  24'h1fd004  // address bits 31..8

// words held by each memory bank
`define DBUS_MEM_WORDS  256

// clock cycles per UART bit
`define DBUS_UART_DIV   8

`endif

//--- design/dbus_pkg.sv
package dbus_pkg;

    // master byte address
    typedef logic [31:0] addr_t;

    // one bus data word
    typedef logic [31:0] data_t;

    // one enable per byte lane, bit 0 is the low byte
    typedef logic [3:0] be_t;

    // target chosen by the address decoder
    typedef enum logic [2:0] {
        REGION_NONE,  // unmapped, reads zero and drops writes
        REGION_RAM,
        REGION_FLASH,
        REGION_UART,
        REGION_GPIO
    } region_e;

endpackage

//--- design/dbus.sv
`include "dbus_macros.svh"

module dbus
    import dbus_pkg::*;
(
    input  addr_t       master_address_i,
    input  be_t         master_byteenable_i,
    input  logic        master_read_i,
    input  logic        master_write_i,
    input  data_t       master_wrdata_i,
    output data_t       master_rddata_o,
    output logic        master_stall_o,

    input  data_t       ram_rd_data_i,
    input  data_t       flash_rd_data_i,
    input  data_t       uart_rd_data_i,
    input  data_t       gpio_rd_data_i,
    input  logic        ram_stall_i,

    output logic [23:0] ram_addr_o,
    output logic [23:0] flash_addr_o,
    output logic [3:0]  uart_addr_o,
    output logic [7:0]  gpio_addr_o,
    output data_t       wr_data_o,
    output be_t         byteenable_o,

    output logic        ram_rd_o,
    output logic        ram_wr_o,
    output logic        flash_rd_o,
    output logic        flash_wr_o,
    output logic        uart_rd_o,
    output logic        uart_wr_o,
    output logic        gpio_rd_o,
    output logic        gpio_wr_o
);

    region_e region;

    // first match wins, so RAM shadows everything below it
    always_comb begin
        if (master_address_i[31:24] == `DBUS_RAM_BASE) begin
            region = REGION_RAM;
        end else if (master_address_i[31:24] == `DBUS_FLASH_BASE) begin
            region = REGION_FLASH;
        end else if (master_address_i[31:4] == `DBUS_UART_BASE) begin
            region = REGION_UART;
        end else if (master_address_i[31:8] == `DBUS_GPIO_BASE) begin
            region = REGION_GPIO;
        end else begin
            region = REGION_NONE;
        end
    end

    // the slaves only see the offset inside their own window
    assign ram_addr_o   = master_address_i[23:0];
    assign flash_addr_o = master_address_i[23:0];
    assign uart_addr_o  = master_address_i[3:0];
    assign gpio_addr_o  = master_address_i[7:0];

    assign wr_data_o    = master_wrdata_i;
    assign byteenable_o = master_byteenable_i;

    assign ram_rd_o   = master_read_i  && (region == REGION_RAM);
    assign ram_wr_o   = master_write_i && (region == REGION_RAM);
    assign flash_rd_o = master_read_i  && (region == REGION_FLASH);
    assign flash_wr_o = master_write_i && (region == REGION_FLASH);
    assign uart_rd_o  = master_read_i  && (region == REGION_UART);
    assign uart_wr_o  = master_write_i && (region == REGION_UART);
    assign gpio_rd_o  = master_read_i  && (region == REGION_GPIO);
    assign gpio_wr_o  = master_write_i && (region == REGION_GPIO);

    always_comb begin
        master_rddata_o = '0;
        master_stall_o  = 1'b0;
        case (region)
            REGION_RAM: begin
                master_rddata_o = ram_rd_data_i;
                master_stall_o  = ram_stall_i; // only RAM ever holds the master
            end
            REGION_FLASH: master_rddata_o = flash_rd_data_i;
            REGION_UART:  master_rddata_o = uart_rd_data_i;
            REGION_GPIO:  master_rddata_o = gpio_rd_data_i;
            default:      master_rddata_o = '0;
        endcase
    end

endmodule

//--- design/mem_bank.sv
`include "dbus_macros.svh"

module mem_bank
    import dbus_pkg::*;
#(
    parameter int unsigned WAIT_STATES = 0,
    parameter int unsigned WORDS       = `DBUS_MEM_WORDS
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic [23:0] addr_i,
    input  data_t       wr_data_i,
    input  be_t         byteenable_i,
    input  logic        rd_i,
    input  logic        wr_i,
    output data_t       rd_data_o,
    output logic        stall_o
);

    localparam int unsigned IDX_W = $clog2(WORDS);

    data_t              mem [WORDS];
    logic [IDX_W-1:0]   word_idx;

    // bits above the index are ignored, so the bank repeats through its window
    assign word_idx = addr_i[IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable_i[b]) begin
                    mem[word_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    if (WAIT_STATES == 0) begin : g_no_wait

        assign rd_data_o = rd_i ? mem[word_idx] : '0;
        assign stall_o   = 1'b0;

    end else begin : g_one_wait

        logic  wait_q; // set during the second cycle of a read
        data_t rd_q;

        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                wait_q <= 1'b0;
            end else begin
                wait_q <= rd_i && !wait_q; // a held read starts over after completing
            end
        end

        always_ff @(posedge clk_i) begin
            if (rd_i && !wait_q) begin
                rd_q <= mem[word_idx];
            end
        end

        assign stall_o   = rd_i && !wait_q;
        assign rd_data_o = rd_q;

    end

endmodule

//--- design/uart_tx.sv
`include "dbus_macros.svh"

module uart_tx
    import dbus_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic [3:0] addr_i,
    input  data_t      wr_data_i,
    input  logic       rd_i,
    input  logic       wr_i,
    output data_t      rd_data_o,
    output logic       tx_o
);

    localparam int unsigned DIV   = `DBUS_UART_DIV;
    localparam int unsigned CNT_W = $clog2(DIV);

    logic [7:0]       data_q;  // last accepted byte
    logic [8:0]       shift_q; // bits still to send, stop bit on top
    logic [CNT_W-1:0] div_cnt;
    logic [3:0]       bit_idx; // 0 is the start bit, 9 the stop bit
    logic             busy_q;
    logic             tx_q;
    logic             accept;
    logic             bit_end;

    assign accept  = wr_i && (addr_i == 4'h0) && !busy_q; // writes while busy are lost
    assign bit_end = (div_cnt == CNT_W'(DIV - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            tx_q    <= 1'b1; // line idles high
            div_cnt <= '0;
            bit_idx <= '0;
        end else if (accept) begin
            busy_q  <= 1'b1;
            tx_q    <= 1'b0;
            div_cnt <= '0;
            bit_idx <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                div_cnt <= '0;
                if (bit_idx == 4'd9) begin
                    busy_q <= 1'b0;
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                    tx_q    <= shift_q[0];
                end
            end else begin
                div_cnt <= div_cnt + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            data_q  <= wr_data_i[7:0];
            shift_q <= {1'b1, wr_data_i[7:0]};
        end else if (busy_q && bit_end) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    assign tx_o = tx_q;

    always_comb begin
        rd_data_o = '0;
        if (rd_i) begin
            case (addr_i)
                4'h0:    rd_data_o = {24'h0, data_q};
                4'h4:    rd_data_o = {31'h0, busy_q};
                default: rd_data_o = '0;
            endcase
        end
    end

endmodule

//--- design/gpio_port.sv
module gpio_port
    import dbus_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic [7:0] addr_i,
    input  data_t      wr_data_i,
    input  logic       rd_i,
    input  logic       wr_i,
    input  data_t      gpio_in_i,
    output data_t      rd_data_o,
    output data_t      gpio_out_o
);

    data_t out_q;
    data_t in_meta_q; // first stage, may go metastable
    data_t in_sync_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_q <= '0;
        end else if (wr_i && (addr_i == 8'h00)) begin
            out_q <= wr_data_i;
        end
    end

    // pins are asynchronous to the bus clock
    always_ff @(posedge clk_i) begin
        in_meta_q <= gpio_in_i;
        in_sync_q <= in_meta_q;
    end

    assign gpio_out_o = out_q;

    always_comb begin
        rd_data_o = '0;
        if (rd_i) begin
            case (addr_i)
                8'h00:   rd_data_o = out_q;
                8'h04:   rd_data_o = in_sync_q;
                default: rd_data_o = '0;
            endcase
        end
    end

endmodule

//--- design/dbus_top.sv
`include "dbus_macros.svh"

module dbus_top
    import dbus_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  addr_t master_address_i,
    input  be_t   master_byteenable_i,
    input  logic  master_read_i,
    input  logic  master_write_i,
    input  data_t master_wrdata_i,
    input  data_t gpio_in_i,
    output data_t master_rddata_o,
    output logic  master_stall_o,
    output logic  tx_o,
    output data_t gpio_out_o
);

    logic [23:0] ram_addr;
    logic [23:0] flash_addr;
    logic [3:0]  uart_addr;
    logic [7:0]  gpio_addr;
    data_t       wr_data;
    be_t         byteenable;
    data_t       ram_rd_data;
    data_t       flash_rd_data;
    data_t       uart_rd_data;
    data_t       gpio_rd_data;
    logic        ram_stall;
    logic        ram_rd;
    logic        ram_wr;
    logic        flash_rd;
    logic        flash_wr;
    logic        uart_rd;
    logic        uart_wr;
    logic        gpio_rd;
    logic        gpio_wr;

    dbus dbus_i (
        .master_address_i    (master_address_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_wrdata_i     (master_wrdata_i),
        .master_rddata_o     (master_rddata_o),
        .master_stall_o      (master_stall_o),
        .ram_rd_data_i       (ram_rd_data),
        .flash_rd_data_i     (flash_rd_data),
        .uart_rd_data_i      (uart_rd_data),
        .gpio_rd_data_i      (gpio_rd_data),
        .ram_stall_i         (ram_stall),
        .ram_addr_o          (ram_addr),
        .flash_addr_o        (flash_addr),
        .uart_addr_o         (uart_addr),
        .gpio_addr_o         (gpio_addr),
        .wr_data_o           (wr_data),
        .byteenable_o        (byteenable),
        .ram_rd_o            (ram_rd),
        .ram_wr_o            (ram_wr),
        .flash_rd_o          (flash_rd),
        .flash_wr_o          (flash_wr),
        .uart_rd_o           (uart_rd),
        .uart_wr_o           (uart_wr),
        .gpio_rd_o           (gpio_rd),
        .gpio_wr_o           (gpio_wr)
    );

    mem_bank #(
        .WAIT_STATES (1),
        .WORDS       (`DBUS_MEM_WORDS)
    ) ram_bank (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .addr_i       (ram_addr),
        .wr_data_i    (wr_data),
        .byteenable_i (byteenable),
        .rd_i         (ram_rd),
        .wr_i         (ram_wr),
        .rd_data_o    (ram_rd_data),
        .stall_o      (ram_stall)
    );

    mem_bank #(
        .WAIT_STATES (0),
        .WORDS       (`DBUS_MEM_WORDS)
    ) flash_bank (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .addr_i       (flash_addr),
        .wr_data_i    (wr_data),
        .byteenable_i (byteenable),
        .rd_i         (flash_rd),
        .wr_i         (flash_wr),
        .rd_data_o    (flash_rd_data),
        .stall_o      ()              // flash has no wait state
    );

    uart_tx uart_i (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .addr_i    (uart_addr),
        .wr_data_i (wr_data),
        .rd_i      (uart_rd),
        .wr_i      (uart_wr),
        .rd_data_o (uart_rd_data),
        .tx_o      (tx_o)
    );

    gpio_port gpio_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .addr_i     (gpio_addr),
        .wr_data_i  (wr_data),
        .rd_i       (gpio_rd),
        .wr_i       (gpio_wr),
        .gpio_in_i  (gpio_in_i),
        .rd_data_o  (gpio_rd_data),
        .gpio_out_o (gpio_out_o)
    );

endmodule

//--- verif/dbus_tb.sv
`include "dbus_macros.svh"

module dbus_tb
    import dbus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 3000; // two uart frames plus memory traffic stay well below

    logic  clk;
    logic  reset;
    addr_t address;
    be_t   byteenable;
    logic  rd;
    logic  wr;
    data_t wrdata;
    data_t gpio_in;
    data_t rddata;
    logic  stall;
    logic  tx;
    data_t gpio_out;

    int    seed = 7656;
    int    cycles = 0;
    data_t ram_model [`DBUS_MEM_WORDS];
    data_t flash_model [`DBUS_MEM_WORDS];
    data_t gpio_out_model;

    dbus_top dut_i (
        .clk_i               (clk),
        .reset_i             (reset),
        .master_address_i    (address),
        .master_byteenable_i (byteenable),
        .master_read_i       (rd),
        .master_write_i      (wr),
        .master_wrdata_i     (wrdata),
        .gpio_in_i           (gpio_in),
        .master_rddata_o     (rddata),
        .master_stall_o      (stall),
        .tx_o                (tx),
        .gpio_out_o          (gpio_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("TEST FAIL");
            $fatal(1, "timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    task automatic check_data(input string what, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s, expected %h, got %h", $time, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_level(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s, expected %b, got %b", $time, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "level mismatch");
        end
    endtask

    // model index, the bank only decodes the low word address bits
    function automatic int word_of(input addr_t addr);
        return (addr >> 2) % `DBUS_MEM_WORDS;
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    // every bus task starts and ends 10 ns after a rising edge
    task automatic bus_write(input addr_t addr, input data_t data, input be_t be);
        logic stalled;
        address    = addr;
        byteenable = be;
        wrdata     = data;
        wr         = 1'b1;
        stalled    = 1'b1;
        while (stalled) begin
            @(negedge clk);
            stalled = stall;
            @(posedge clk);
        end
        #10;
        wr = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, output data_t data,
                            output logic first_stall, output logic second_stall);
        int   n;
        logic stalled;
        address      = addr;
        byteenable   = 4'hf;
        rd           = 1'b1;
        n            = 0;
        first_stall  = 1'b0;
        second_stall = 1'b0;
        stalled      = 1'b1;
        while (stalled) begin
            @(negedge clk);
            stalled = stall;
            if (n == 0) first_stall = stall;
            if (n == 1) second_stall = stall;
            data = rddata; // valid in the cycle where stall drops
            n++;
            @(posedge clk);
        end
        #10;
        rd = 1'b0;
    endtask

    task automatic read_and_compare(input string what, input addr_t addr, input data_t expected,
                                    input logic exp_stall);
        data_t data;
        logic  first_stall;
        logic  second_stall;
        bus_read(addr, data, first_stall, second_stall);
        check_data(what, expected, data);
        check_level({what, " stall in first cycle"}, exp_stall, first_stall);
        if (exp_stall) begin
            check_level({what, " stall in second cycle"}, 1'b0, second_stall);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // starts right after the accepting write, samples each bit in the middle of its period
    task automatic check_frame(input logic [7:0] value);
        logic exp_bit;
        repeat (`DBUS_UART_DIV / 2) @(posedge clk);
        for (int k = 0; k < 10; k++) begin
            if (k == 0) exp_bit = 1'b0;
            else if (k == 9) exp_bit = 1'b1;
            else exp_bit = value[k-1];
            @(negedge clk);
            check_level($sformatf("uart tx bit %0d", k), exp_bit, tx);
            if (k < 9) repeat (`DBUS_UART_DIV) @(posedge clk);
        end
    endtask

    // the stop bit ends less than one bit period after its middle sample
    task automatic wait_uart_idle();
        data_t status;
        logic  first_stall;
        logic  second_stall;
        int    polls;
        status = 32'h1;
        polls  = 0;
        while (status[0] && polls < `DBUS_UART_DIV) begin
            bus_read(32'h1fd0_03f4, status, first_stall, second_stall);
            polls++;
        end
        check_data("uart status after frame", 32'h0, status);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_level("tx after reset", 1'b1, tx);
        check_data("gpio_out after reset", 32'h0, gpio_out);
        check_level("stall after reset", 1'b0, stall);
        @(posedge clk);
        #10;
    endtask

    task automatic test_ram();
        data_t data;
        be_t   be;
        for (int i = 0; i < 8; i++) begin
            data = data_t'($random(seed));
            bus_write(addr_t'(i * 4), data, 4'hf);
            ram_model[i] = data;
        end
        for (int i = 0; i < 8; i++) begin
            data = data_t'($random(seed));
            be   = be_t'($random(seed));
            bus_write(addr_t'(i * 4), data, be);
            ram_model[i] = merge_bytes(ram_model[i], data, be);
        end
        for (int i = 0; i < 8; i++) begin
            read_and_compare("ram readback", addr_t'(i * 4), ram_model[i], 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            read_and_compare("ram alias read", 32'h0012_3400 + i * 4, ram_model[i], 1'b1);
        end
        data = data_t'($random(seed));
        bus_write(32'h00ab_c010, data, 4'hf); // bits 23..10 differ, same word as 0x10
        ram_model[word_of(32'h00ab_c010)] = data;
        read_and_compare("ram alias write", 32'h0000_0010, ram_model[4], 1'b1);
    endtask

    task automatic test_flash();
        data_t data;
        addr_t addr;
        for (int i = 0; i < 8; i++) begin
            addr = 32'h1e00_0000 + i * 4;
            data = data_t'($random(seed));
            bus_write(addr, data, 4'hf);
            flash_model[word_of(addr)] = data;
        end
        data = data_t'($random(seed));
        bus_write(32'h1e00_0008, data, 4'b0101);
        flash_model[2] = merge_bytes(flash_model[2], data, 4'b0101);
        for (int i = 0; i < 8; i++) begin
            read_and_compare("flash readback", 32'h1e00_0000 + i * 4, flash_model[i], 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            read_and_compare("ram beside flash", addr_t'(i * 4), ram_model[i], 1'b1);
        end
    endtask

    task automatic test_uart();
        bus_write(32'h1fd0_03f0, 32'h0000_00a5, 4'hf);
        fork
            check_frame(8'ha5);
            begin
                read_and_compare("uart busy during frame", 32'h1fd0_03f4, 32'h1, 1'b0);
                idle(5);
                bus_write(32'h1fd0_03f0, 32'h0000_003c, 4'hf); // lost, frame in flight
                read_and_compare("uart data after dropped write", 32'h1fd0_03f0,
                                 32'h0000_00a5, 1'b0);
            end
        join
        @(posedge clk);
        #10;
        wait_uart_idle();
        check_level("tx idle after frame", 1'b1, tx);
        bus_write(32'h1fd0_03f0, 32'h0000_0096, 4'hf);
        check_frame(8'h96);
        @(posedge clk);
        #10;
        wait_uart_idle();
        read_and_compare("uart data second frame", 32'h1fd0_03f0, 32'h0000_0096, 1'b0);
    endtask

    task automatic test_gpio();
        data_t pins;
        gpio_out_model = data_t'($random(seed));
        bus_write(32'h1fd0_0400, gpio_out_model, 4'hf);
        @(negedge clk);
        check_data("gpio_out pins", gpio_out_model, gpio_out);
        @(posedge clk);
        #10;
        read_and_compare("gpio out register", 32'h1fd0_0400, gpio_out_model, 1'b0);
        pins    = data_t'($random(seed));
        gpio_in = pins;
        idle(3); // two synchronizer flops
        read_and_compare("gpio input pins", 32'h1fd0_0404, pins, 1'b0);
        read_and_compare("gpio unused offset", 32'h1fd0_0408, 32'h0, 1'b0);
    endtask

    task automatic test_unmapped();
        read_and_compare("unmapped read", 32'h4000_0000, 32'h0, 1'b0);
        bus_write(32'h4000_0000, 32'hffff_ffff, 4'hf);
        read_and_compare("ram after unmapped write", 32'h0000_0000, ram_model[0], 1'b1);
        read_and_compare("flash after unmapped write", 32'h1e00_0000, flash_model[0], 1'b0);
        read_and_compare("gpio after unmapped write", 32'h1fd0_0400, gpio_out_model, 1'b0);
        check_data("gpio_out after unmapped write", gpio_out_model, gpio_out);
    endtask

    initial begin
        reset      = 1'b1;
        address    = '0;
        byteenable = '0;
        rd         = 1'b0;
        wr         = 1'b0;
        wrdata     = '0;
        gpio_in    = '0;
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;

        test_reset_state();
        test_ram();
        test_flash();
        test_uart();
        test_gpio();
        test_unmapped();

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- flist.f
+incdir+design
design/dbus_pkg.sv
design/dbus.sv
design/mem_bank.sv
design/uart_tx.sv
design/gpio_port.sv
design/dbus_top.sv
verif/dbus_tb.sv
